//--- sim.f
+incdir+.
vga_pkg.sv
game_pkg.sv
vga_timing.sv
char_draw.sv
sprite_arbiter.sv
sprite_rom.sv
game_top.sv
tb_game.sv

//--- tb_game.sv
// Runs ten frames of fixed and random setups; inputs that affect drawing change only in vblank
`default_nettype none

`include "game_defines.svh"

module tb_game;
    timeunit 1ns;
    timeprecision 100ps;

    import vga_pkg::*;
    import game_pkg::*;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int CYCLE_LIMIT  = 12 * FRAME_CYCLES + 200;

    logic        clk;
    logic        rst;
    coord_t      p0_pos_x;
    coord_t      p0_pos_y;
    health_t     p0_current_health;
    logic        p0_flip_h;
    char_class_t p0_char_class;
    aggro_t      p0_class_aggro;
    coord_t      p1_pos_x;
    coord_t      p1_pos_y;
    health_t     p1_current_health;
    logic        p1_flip_h;
    char_class_t p1_char_class;
    aggro_t      p1_class_aggro;
    game_state_t game_state;
    aggro_t      p0_char_aggro;
    aggro_t      p1_char_aggro;
    logic        p0_alive;
    logic        p1_alive;
    coord_t      hcount;
    coord_t      vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    rgb_t        rgb;

    logic [31:0] rng = 32'hd04e_e3d5;
    int          cycle_count = 0;
    int          reset_edges = 0;
    int          run_cycles = 0;
    int          error_count = 0;

    // Raster position the next checked output pixel must carry
    int          exp_hcount = 0;
    int          exp_vcount = 0;

    game_top dut (.*);

    always #5 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw_random(input int limit, output int value);
        rng = xorshift32(rng);
        value = int'(rng % 32'(limit));
    endtask

    task automatic stop_on_error(input string msg);
        error_count++;
        $display("Error at %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Sprite word of one player at a screen pixel, or -1 when the player is not drawn there
    function automatic int player_word(input int h, input int v, input int px, input int py,
                                       input logic flip, input logic shown, input int code);
        int rx;
        int ry;
        int ix;
        rx = h + `SPR_HALF_W - px;
        ry = v + `SPR_HALF_H - py;
        if (!shown || rx < 0 || rx >= `SPR_W || ry < 0 || ry >= `SPR_H) begin
            return -1;
        end
        ix = flip ? (`SPR_W - 1 - rx) : rx;
        if (ix == 0 || ix == `SPR_W - 1) begin
            return `COLOR_KEY;
        end
        return (ix << 8) | ((ry % 16) << 4) | code;
    endfunction

    // --------------------------------------------------
    // Reference model and checks
    // --------------------------------------------------
    task automatic check_pixel();
        int          h;
        int          v;
        int          w0;
        int          w1;
        logic        shown0;
        logic        shown1;
        logic [11:0] exp_rgb;
        h = int'(hcount);
        v = int'(vcount);
        assert (h == exp_hcount && v == exp_vcount)
            else stop_on_error($sformatf("output at (%0d,%0d), expected (%0d,%0d)",
                                         h, v, exp_hcount, exp_vcount));
        exp_hcount = (h == `H_TOTAL - 1) ? 0 : h + 1;
        exp_vcount = (h != `H_TOTAL - 1) ? v : ((v == `V_TOTAL - 1) ? 0 : v + 1);
        assert (hsync === (h >= `H_SYNC_START && h < `H_SYNC_END))
            else stop_on_error($sformatf("hsync %b wrong at hcount %0d", hsync, h));
        assert (vsync === (v >= `V_SYNC_START && v < `V_SYNC_END))
            else stop_on_error($sformatf("vsync %b wrong at vcount %0d", vsync, v));
        assert (hblnk === (h >= `H_ACTIVE))
            else stop_on_error($sformatf("hblnk %b wrong at hcount %0d", hblnk, h));
        assert (vblnk === (v >= `V_ACTIVE))
            else stop_on_error($sformatf("vblnk %b wrong at vcount %0d", vblnk, v));
        shown0 = (game_state == GS_PLAYING) && (p0_current_health != 0) &&
                 (p0_char_class != CC_NONE);
        shown1 = (game_state == GS_PLAYING) && (p1_current_health != 0) &&
                 (p1_char_class != CC_NONE);
        if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
            exp_rgb = 12'h000;
        end else begin
            w0 = player_word(h, v, int'(p0_pos_x), int'(p0_pos_y), p0_flip_h, shown0,
                             int'(p0_char_class));
            w1 = player_word(h, v, int'(p1_pos_x), int'(p1_pos_y), p1_flip_h, shown1,
                             int'(p1_char_class));
            // Player 0 owns the pixel even where its own word is transparent
            if (w0 >= 0) begin
                exp_rgb = (w0 == `COLOR_KEY) ? `BG_COLOR : 12'(w0);
            end else if (w1 >= 0) begin
                exp_rgb = (w1 == `COLOR_KEY) ? `BG_COLOR : 12'(w1);
            end else begin
                exp_rgb = `BG_COLOR;
            end
        end
        assert (rgb === exp_rgb)
            else stop_on_error($sformatf("rgb %h at (%0d,%0d), expected %h", rgb, h, v, exp_rgb));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst) begin
            reset_edges <= reset_edges + 1;
        end else begin
            run_cycles <= run_cycles + 1;
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the frames did not complete within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        assert (p0_alive === (p0_current_health != 0))
            else stop_on_error("player 0 alive does not follow health");
        assert (p1_alive === (p1_current_health != 0))
            else stop_on_error("player 1 alive does not follow health");
        assert (p0_char_aggro === ((p0_current_health != 0) ? p0_class_aggro : 4'd0))
            else stop_on_error($sformatf("player 0 aggro %h is wrong", p0_char_aggro));
        assert (p1_char_aggro === ((p1_current_health != 0) ? p1_class_aggro : 4'd0))
            else stop_on_error($sformatf("player 1 aggro %h is wrong", p1_char_aggro));
        if (rst) begin
            if (reset_edges > 0) begin
                assert (hblnk === 1'b1 && vblnk === 1'b1 && rgb === 12'h000)
                    else stop_on_error("outputs are not blanked during reset");
                // The default spot is a fifth of the way across, on the ground line
                assert (dut.u_char_draw_p0.draw_x === coord_t'(`H_ACTIVE / 5) &&
                        dut.u_char_draw_p0.draw_y === coord_t'(`V_ACTIVE - 4 - `SPR_HALF_H))
                    else stop_on_error("player 0 does not start at the default position");
                assert (dut.u_char_draw_p1.draw_x === coord_t'(`H_ACTIVE / 5) &&
                        dut.u_char_draw_p1.draw_y === coord_t'(`V_ACTIVE - 4 - `SPR_HALF_H))
                    else stop_on_error("player 1 does not start at the default position");
            end
        end else if (run_cycles >= 2) begin
            // The first cycle after reset still shows the reset contents of the pipeline
            check_pixel();
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic set_player0(input int x, input int y, input int cls, input logic flip,
                               input int hp);
        p0_pos_x          = coord_t'(x);
        p0_pos_y          = coord_t'(y);
        p0_char_class     = char_class_t'(cls);
        p0_flip_h         = flip;
        p0_current_health = health_t'(hp);
    endtask

    task automatic set_player1(input int x, input int y, input int cls, input logic flip,
                               input int hp);
        p1_pos_x          = coord_t'(x);
        p1_pos_y          = coord_t'(y);
        p1_char_class     = char_class_t'(cls);
        p1_flip_h         = flip;
        p1_current_health = health_t'(hp);
    endtask

    task automatic setup_frame(input int f);
        int x0;
        int y0;
        int c0;
        int h0;
        int x1;
        int y1;
        int c1;
        int h1;
        int flips;
        game_state = GS_PLAYING;
        case (f)
            0: begin
                set_player0(`H_ACTIVE / 5, `V_ACTIVE - 4 - `SPR_HALF_H, 1, 1'b0, 5);
                set_player1(50, 10, 2, 1'b0, 9);
            end
            1: begin
                set_player0(40, 30, 2, 1'b1, 3);
                set_player1(10, 12, 1, 1'b1, 15);
            end
            // Overlapping boxes, with player 0's right edge column inside player 1's box
            2: begin
                set_player0(30, 20, 1, 1'b0, 7);
                set_player1(34, 24, 2, 1'b1, 7);
            end
            3: game_state = GS_MENU;
            4: begin
                set_player0(20, 20, 0, 1'b0, 8);
                set_player1(44, 26, 1, 1'b0, 0);
            end
            // Both players would be drawn here if the game were still running
            5: begin
                game_state = GS_OVER;
                set_player0(20, 20, 1, 1'b0, 8);
                set_player1(44, 26, 2, 1'b1, 4);
            end
            default: begin
                draw_random(`H_ACTIVE, x0);
                draw_random(`V_ACTIVE, y0);
                draw_random(3, c0);
                draw_random(16, h0);
                draw_random(`H_ACTIVE, x1);
                draw_random(`V_ACTIVE, y1);
                draw_random(3, c1);
                draw_random(16, h1);
                draw_random(4, flips);
                set_player0(x0, y0, c0, flips[0], h0);
                set_player1(x1, y1, c1, flips[1], h1);
            end
        endcase
    endtask

    // Runs until the output has left the visible part of the frame, with fresh aggro each cycle
    task automatic run_frame();
        do begin
            @(posedge clk);
            #1;
            rng = xorshift32(rng);
            p0_class_aggro = rng[3:0];
            p1_class_aggro = rng[7:4];
        end while (!(vcount == coord_t'(`V_ACTIVE) && hcount == '0));
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        p0_class_aggro = 4'd2;
        p1_class_aggro = 4'd6;
        setup_frame(0);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int f = 0; f < 10; f++) begin
            if (f > 0) begin
                setup_frame(f);
            end
            run_frame();
        end
        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- game_top.sv
// Output raster lags the timing generator by two clocks; inputs are sampled per pixel, no stalls
`default_nettype none

`include "game_defines.svh"

module game_top (
    input  logic                  clk,
    input  logic                  rst,
    input  vga_pkg::coord_t       p0_pos_x,
    input  vga_pkg::coord_t       p0_pos_y,
    input  game_pkg::health_t     p0_current_health,
    input  logic                  p0_flip_h,
    input  game_pkg::char_class_t p0_char_class,
    input  game_pkg::aggro_t      p0_class_aggro,
    input  vga_pkg::coord_t       p1_pos_x,
    input  vga_pkg::coord_t       p1_pos_y,
    input  game_pkg::health_t     p1_current_health,
    input  logic                  p1_flip_h,
    input  game_pkg::char_class_t p1_char_class,
    input  game_pkg::aggro_t      p1_class_aggro,
    input  game_pkg::game_state_t game_state,
    output game_pkg::aggro_t      p0_char_aggro,
    output game_pkg::aggro_t      p1_char_aggro,
    output logic                  p0_alive,
    output logic                  p1_alive,
    output vga_pkg::coord_t       hcount,
    output vga_pkg::coord_t       vcount,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  hblnk,
    output logic                  vblnk,
    output vga_pkg::rgb_t         rgb
);
    import vga_pkg::*;

    // Raw raster from the timing generator
    coord_t tim_hcount;
    coord_t tim_vcount;
    logic   tim_hsync;
    logic   tim_vsync;
    logic   tim_hblnk;
    logic   tim_vblnk;
    rgb_t   tim_rgb;

    // Sprite requests and memory path
    logic                   req0;
    logic                   req1;
    logic [`SPR_ADDR_W-1:0] addr0;
    logic [`SPR_ADDR_W-1:0] addr1;
    logic [`SPR_ADDR_W-1:0] rom_addr;
    rgb_t                   rom_data;

    // ------------------------------------------------
    // Raster source
    // ------------------------------------------------
    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk),
        .rgb    (tim_rgb)
    );

    // ------------------------------------------------
    // Player stages
    // ------------------------------------------------
    char_draw u_char_draw_p0 (
        .clk            (clk),
        .rst            (rst),
        .pos_x          (p0_pos_x),
        .pos_y          (p0_pos_y),
        .current_health (p0_current_health),
        .flip_h         (p0_flip_h),
        .game_state     (game_state),
        .char_class     (p0_char_class),
        .class_aggro    (p0_class_aggro),
        .hcount         (tim_hcount),
        .vcount         (tim_vcount),
        .hblnk          (tim_hblnk),
        .vblnk          (tim_vblnk),
        .char_aggro     (p0_char_aggro),
        .alive          (p0_alive),
        .req            (req0),
        .addr           (addr0)
    );

    char_draw u_char_draw_p1 (
        .clk            (clk),
        .rst            (rst),
        .pos_x          (p1_pos_x),
        .pos_y          (p1_pos_y),
        .current_health (p1_current_health),
        .flip_h         (p1_flip_h),
        .game_state     (game_state),
        .char_class     (p1_char_class),
        .class_aggro    (p1_class_aggro),
        .hcount         (tim_hcount),
        .vcount         (tim_vcount),
        .hblnk          (tim_hblnk),
        .vblnk          (tim_vblnk),
        .char_aggro     (p1_char_aggro),
        .alive          (p1_alive),
        .req            (req1),
        .addr           (addr1)
    );

    // ------------------------------------------------
    // Shared sprite memory and compositing
    // ------------------------------------------------
    sprite_arbiter u_sprite_arbiter (
        .clk       (clk),
        .rst       (rst),
        .req0      (req0),
        .req1      (req1),
        .addr0     (addr0),
        .addr1     (addr1),
        .hcount_in (tim_hcount),
        .vcount_in (tim_vcount),
        .hsync_in  (tim_hsync),
        .vsync_in  (tim_vsync),
        .hblnk_in  (tim_hblnk),
        .vblnk_in  (tim_vblnk),
        .rgb_in    (tim_rgb),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync     (hsync),
        .vsync     (vsync),
        .hblnk     (hblnk),
        .vblnk     (vblnk),
        .rgb       (rgb)
    );

    sprite_rom u_sprite_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

endmodule

`default_nettype wire

//--- sprite_rom.sv
// Contents are generated at start-up from the pattern rule; addresses past 319 in a class are unused
`default_nettype none

`include "game_defines.svh"

module sprite_rom (
    input  logic                   clk,
    input  logic [`SPR_ADDR_W-1:0] addr,
    output vga_pkg::rgb_t          data
);
    import vga_pkg::*;

    // Index 0 is the melee image, index 1 the archer image
    rgb_t mem [0:1][0:`SPR_W*`SPR_H-1];

    // ------------------------------------------------
    // Pattern fill
    // ------------------------------------------------

    // Edge columns are transparent. Other words carry column, row mod 16 and class code
    initial begin
        for (int c = 0; c < 2; c++) begin
            for (int y = 0; y < `SPR_H; y++) begin
                for (int x = 0; x < `SPR_W; x++) begin
                    if (x == 0 || x == `SPR_W - 1) begin
                        mem[c][y*`SPR_W + x] = `COLOR_KEY;
                    end else begin
                        mem[c][y*`SPR_W + x] = {4'(x), 4'(y % 16), 4'(c + 1)};
                    end
                end
            end
        end
    end

    // ------------------------------------------------
    // Registered read
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        data <= mem[addr[`SPR_ADDR_W-1]][addr[`SPR_ADDR_W-2:0]];
    end

endmodule

`default_nettype wire

//--- sprite_arbiter.sv
// Player 0 always wins the memory; a losing request is dropped, with no grant sent back
`default_nettype none

`include "game_defines.svh"

module sprite_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req0,
    input  logic                   req1,
    input  logic [`SPR_ADDR_W-1:0] addr0,
    input  logic [`SPR_ADDR_W-1:0] addr1,
    input  vga_pkg::coord_t        hcount_in,
    input  vga_pkg::coord_t        vcount_in,
    input  logic                   hsync_in,
    input  logic                   vsync_in,
    input  logic                   hblnk_in,
    input  logic                   vblnk_in,
    input  vga_pkg::rgb_t          rgb_in,
    output logic [`SPR_ADDR_W-1:0] rom_addr,
    input  vga_pkg::rgb_t          rom_data,
    output vga_pkg::coord_t        hcount,
    output vga_pkg::coord_t        vcount,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   hblnk,
    output logic                   vblnk,
    output vga_pkg::rgb_t          rgb
);
    import vga_pkg::*;

    coord_t hcount_d;
    coord_t vcount_d;
    logic   hsync_d;
    logic   vsync_d;
    logic   hblnk_d;
    logic   vblnk_d;
    rgb_t   rgb_d;
    logic   hit_d;

    // ------------------------------------------------
    // Stage 1: grant and memory read
    // ------------------------------------------------

    // Park the address at zero when nobody asks, so the read stays in range
    always_comb begin
        if (req0) begin
            rom_addr = addr0;
        end else if (req1) begin
            rom_addr = addr1;
        end else begin
            rom_addr = '0;
        end
    end

    // Raster signals wait here for the memory word
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_d <= '0;
            vcount_d <= '0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
            hblnk_d  <= 1'b1;
            vblnk_d  <= 1'b1;
            hit_d    <= 1'b0;
        end else begin
            hcount_d <= hcount_in;
            vcount_d <= vcount_in;
            hsync_d  <= hsync_in;
            vsync_d  <= vsync_in;
            hblnk_d  <= hblnk_in;
            vblnk_d  <= vblnk_in;
            hit_d    <= req0 || req1;
        end
    end

    always_ff @(posedge clk) begin
        rgb_d <= rgb_in;
    end

    // ------------------------------------------------
    // Stage 2: colour-key compositing
    // ------------------------------------------------

    // A transparent winner pixel falls back to background, never to the loser
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b1;
            vblnk  <= 1'b1;
            rgb    <= '0;
        end else begin
            hcount <= hcount_d;
            vcount <= vcount_d;
            hsync  <= hsync_d;
            vsync  <= vsync_d;
            hblnk  <= hblnk_d;
            vblnk  <= vblnk_d;
            if (hit_d && (rom_data != `COLOR_KEY)) begin
                rgb <= rom_data;
            end else begin
                rgb <= rgb_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- char_draw.sv
// Box test uses modular offsets, so positions closer than a half-extent to an edge clip cleanly
`default_nettype none

`include "game_defines.svh"

module char_draw (
    input  logic                     clk,
    input  logic                     rst,
    input  vga_pkg::coord_t          pos_x,
    input  vga_pkg::coord_t          pos_y,
    input  game_pkg::health_t        current_health,
    input  logic                     flip_h,
    input  game_pkg::game_state_t    game_state,
    input  game_pkg::char_class_t    char_class,
    input  game_pkg::aggro_t         class_aggro,
    input  vga_pkg::coord_t          hcount,
    input  vga_pkg::coord_t          vcount,
    input  logic                     hblnk,
    input  logic                     vblnk,
    output game_pkg::aggro_t         char_aggro,
    output logic                     alive,
    output logic                     req,
    output logic [`SPR_ADDR_W-1:0]   addr
);
    import vga_pkg::*;
    import game_pkg::*;

    coord_t     draw_x;
    coord_t     draw_y;
    coord_t     rel_x;
    coord_t     rel_y;
    logic [3:0] img_x;
    logic       in_box;
    logic       archer;

    // ------------------------------------------------
    // Player position
    // ------------------------------------------------

    // Default spot is a fifth of the way across, standing on the ground line
    always_ff @(posedge clk) begin
        if (rst) begin
            draw_x <= coord_t'(`H_ACTIVE / 5);
            draw_y <= coord_t'(`V_ACTIVE - 4 - `SPR_HALF_H);
        end else begin
            draw_x <= pos_x;
            draw_y <= pos_y;
        end
    end

    // ------------------------------------------------
    // Status outputs
    // ------------------------------------------------
    assign alive      = (current_health != '0);
    assign char_aggro = alive ? class_aggro : '0;

    // ------------------------------------------------
    // Sprite box and memory address
    // ------------------------------------------------

    // Offsets from the top-left corner of the box; anything left of or above it
    // wraps to a large value and fails the range check
    assign rel_x  = hcount + coord_t'(`SPR_HALF_W) - draw_x;
    assign rel_y  = vcount + coord_t'(`SPR_HALF_H) - draw_y;
    assign in_box = (rel_x < coord_t'(`SPR_W)) && (rel_y < coord_t'(`SPR_H));

    // Mirror the image column when the player faces the other way
    assign img_x  = flip_h ? (4'(`SPR_W - 1) - rel_x[3:0]) : rel_x[3:0];

    assign archer = (char_class == CC_ARCHER);

    // Class bit on top, then row*16 + column
    assign addr   = {archer, rel_y[4:0], img_x};

    assign req    = (game_state == GS_PLAYING) && alive && (char_class != CC_NONE) &&
                    !hblnk && !vblnk && in_box;

endmodule

`default_nettype wire

//--- vga_timing.sv
// Free-running raster with active-high syncs; counters and syncs reset to zero, no porch tuning
`default_nettype none

`include "game_defines.svh"

module vga_timing (
    input  logic            clk,
    input  logic            rst,
    output vga_pkg::coord_t hcount,
    output vga_pkg::coord_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk,
    output vga_pkg::rgb_t   rgb
);
    import vga_pkg::*;

    coord_t hcount_nxt;
    coord_t vcount_nxt;

    // ------------------------------------------------
    // Counter stepping
    // ------------------------------------------------
    always_comb begin
        hcount_nxt = hcount + coord_t'(1);
        vcount_nxt = vcount;
        if (hcount == coord_t'(`H_TOTAL - 1)) begin
            hcount_nxt = '0;
            if (vcount == coord_t'(`V_TOTAL - 1)) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + coord_t'(1);
            end
        end
    end

    // Syncs are compared against the next count so they stay aligned with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (hcount_nxt >= coord_t'(`H_SYNC_START)) &&
                      (hcount_nxt <  coord_t'(`H_SYNC_END));
            vsync  <= (vcount_nxt >= coord_t'(`V_SYNC_START)) &&
                      (vcount_nxt <  coord_t'(`V_SYNC_END));
        end
    end

    // ------------------------------------------------
    // Blanking and background
    // ------------------------------------------------
    assign hblnk = (hcount >= coord_t'(`H_ACTIVE));
    assign vblnk = (vcount >= coord_t'(`V_ACTIVE));

    // Flat background inside the visible area, black elsewhere
    always_comb begin
        if (hblnk || vblnk) begin
            rgb = '0;
        end else begin
            rgb = `BG_COLOR;
        end
    end

endmodule

`default_nettype wire

//--- game_pkg.sv
// Game-side types; class codes 1 and 2 double as the low nibble of every sprite word
`default_nettype none

package game_pkg;

    // Sprites are only drawn while the game is in GS_PLAYING
    typedef enum logic [1:0] {
        GS_MENU    = 2'd0,
        GS_PLAYING = 2'd1,
        GS_OVER    = 2'd2
    } game_state_t;

    // ------------------------------------------------
    // Character classes
    // ------------------------------------------------

    // CC_NONE means an empty slot and draws nothing
    typedef enum logic [1:0] {
        CC_NONE   = 2'd0,
        CC_MELEE  = 2'd1,
        CC_ARCHER = 2'd2
    } char_class_t;

    // Zero health means the player is dead
    typedef logic [3:0] health_t;

    // Threat level that a living character puts out
    typedef logic [3:0] aggro_t;

endpackage

`default_nettype wire

//--- vga_pkg.sv
// Raster types only; coordinates are unsigned and wide enough for any counter value here
`default_nettype none

package vga_pkg;

    // ------------------------------------------------
    // Screen coordinates
    // ------------------------------------------------

    // Used for the horizontal and vertical counters and for player positions
    typedef logic [11:0] coord_t;

    // ------------------------------------------------
    // Colour
    // ------------------------------------------------

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

`default_nettype wire

//--- game_defines.svh
// Raster is 64x48 visible; SPR_W must equal 2*SPR_HALF_W and SPR_H must equal 2*SPR_HALF_H
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// ------------------------------------------------
// Horizontal raster, in pixels
// ------------------------------------------------
`define H_ACTIVE     64
`define H_TOTAL      80
`define H_SYNC_START 68
`define H_SYNC_END   72

// ------------------------------------------------
// Vertical raster, in lines
// ------------------------------------------------
`define V_ACTIVE     48
`define V_TOTAL      56
`define V_SYNC_START 50
`define V_SYNC_END   52

// ------------------------------------------------
// Sprite geometry and colours
// ------------------------------------------------
`define SPR_W      16
`define SPR_H      20
`define SPR_HALF_W 8
`define SPR_HALF_H 10

`define COLOR_KEY  12'hF00
`define BG_COLOR   12'h222

// Class select bit on top of a 9-bit in-sprite offset
`define SPR_ADDR_W 10

`endif
